// ==== tag_rx_pkg.sv ====
package tag_rx_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SAMPLE_W   = 16;  // I and Q sample width.
  localparam int PHASE_W    = 24;  // One full turn is 2**PHASE_W.
  localparam int LUT_ADDR_W = 10;  // Top phase bits used as table angle.
  localparam int OSC_W      = 16;  // Oscillator amplitude is 32767.
  localparam int MIX_W      = 18;  // Sign, one headroom bit, 16 magnitude bits.
  localparam int GAIN_W     = 18;
  localparam int GAIN_FRAC  = 14;  // 16384 is unity gain.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef logic [PHASE_W-1:0] phase_t;

  typedef logic signed [OSC_W-1:0] osc_t;

  typedef logic signed [MIX_W-1:0] mix_t;

  typedef logic [GAIN_W-1:0] gain_t;

endpackage

// ==== iq_stream_if.sv ====
`timescale 1ns/1ps

// One complex sample per transfer, plus a side field that each link
// types for itself (phase, oscillator pair, or nothing useful).
interface iq_stream_if #(
  parameter type iq_t = logic signed [15:0],
  parameter type ph_t = logic [23:0]
);

  logic valid;
  logic last;
  iq_t  i;
  iq_t  q;
  ph_t  ph;
  logic ready;  // Flows upstream.

  modport source (
    output valid, last, i, q, ph,
    input  ready
  );

  modport sink (
    input  valid, last, i, q, ph,
    output ready
  );

endinterface

// ==== chirp_phase_gen.sv ====
`timescale 1ns/1ps

module chirp_phase_gen import tag_rx_pkg::*; #(
  parameter phase_t      NSIG         = 24'd40960,
  parameter logic [15:0] NSYMB        = 16'd512,
  parameter phase_t      DPH_INC      = 24'hffc000,
  parameter phase_t      START_PH_INC = 24'hfff000,
  parameter phase_t      START_PH     = 24'h000000,
  parameter phase_t      NPH_SHIFT    = 24'h000000,
  parameter int          SYNC_BITS    = 4
) (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_valid,
  input  logic        i_last,
  input  sample_t     i_i,
  input  sample_t     i_q,
  output logic        o_ready,
  iq_stream_if.source o_out,
  output logic        o_sync_ready,
  output phase_t      o_phase,
  output phase_t      o_sample_n,
  output logic [15:0] o_symbol_n
);

  logic [SYNC_BITS-1:0] frame_cnt;
  phase_t               phase;
  phase_t               start_phase;
  phase_t               phase_inc;
  phase_t               sample_n;
  logic [15:0]          symbol_n;
  logic                 started;

  logic    out_valid;
  logic    out_last;
  sample_t out_i;
  sample_t out_q;
  phase_t  out_ph;
  logic    in_xfer;

  assign o_ready = !out_valid || o_out.ready;
  assign in_xfer = i_valid && o_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Chirp counters, stepped once per accepted sample.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (i_rst) begin
      frame_cnt   <= '1;
      phase       <= START_PH;
      start_phase <= START_PH;
      sample_n    <= NSIG;
      symbol_n    <= NSYMB;
      phase_inc   <= START_PH_INC;
      started     <= 1'b0;
    end else if (in_xfer) begin
      started <= 1'b1;
      if (sample_n == NSIG && symbol_n == NSYMB) begin  // End of frame.
        sample_n    <= phase_t'(1);
        symbol_n    <= 16'd1;
        phase       <= START_PH;
        phase_inc   <= START_PH_INC;
        start_phase <= START_PH - NPH_SHIFT;
        frame_cnt   <= frame_cnt + 1'b1;
      end else if (sample_n == NSIG) begin  // Next symbol of the frame.
        sample_n    <= phase_t'(1);
        symbol_n    <= symbol_n + 16'd1;
        phase       <= start_phase;
        phase_inc   <= phase_inc + DPH_INC;
        start_phase <= start_phase - NPH_SHIFT;
      end else begin
        phase    <= phase + phase_inc;
        sample_n <= sample_n + phase_t'(1);
      end
    end
  end

  // Output register. The sample leaves with the phase held before its transfer.
  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_valid <= 1'b0;
    end else if (o_ready) begin
      out_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_last <= i_last;
      out_i    <= i_i;
      out_q    <= i_q;
      out_ph   <= phase;
    end
  end

  assign o_out.valid = out_valid;
  assign o_out.last  = out_last;
  assign o_out.i     = out_i;
  assign o_out.q     = out_q;
  assign o_out.ph    = out_ph;

  assign o_sync_ready = &frame_cnt;
  assign o_phase      = phase;
  assign o_sample_n   = sample_n;
  assign o_symbol_n   = symbol_n;

  a_cnt_range: assert property (@(posedge clk) disable iff (i_rst)
    started |-> (sample_n >= phase_t'(1) && sample_n <= NSIG &&
                 symbol_n >= 16'd1 && symbol_n <= NSYMB));

endmodule

// ==== sincos_lut.sv ====
`timescale 1ns/1ps

module sincos_lut import tag_rx_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  iq_stream_if.sink   i_in,
  iq_stream_if.source o_out
);

  localparam int  QTR = 2 ** (LUT_ADDR_W - 2);  // Table steps per quadrant.
  localparam int  AMP = 2 ** (OSC_W - 1) - 1;
  localparam real PI  = 3.14159265358979;

  // Cosine over the first quadrant, both ends included.
  osc_t cos_rom [0:QTR];

  initial begin
    for (int k = 0; k <= QTR; k++) begin
      cos_rom[k] = osc_t'($rtoi(AMP * $cos(2.0 * PI * k / (4.0 * QTR)) + 0.5));
    end
  end

  logic [LUT_ADDR_W-1:0] addr;
  logic [1:0]            quad;
  logic [LUT_ADDR_W-3:0] off;
  logic [LUT_ADDR_W-2:0] idx_fwd;
  logic [LUT_ADDR_W-2:0] idx_rev;
  osc_t                  c_fwd;
  osc_t                  c_rev;
  osc_t                  cos_v;
  osc_t                  sin_v;

  assign addr    = i_in.ph[PHASE_W-1 -: LUT_ADDR_W];
  assign quad    = addr[LUT_ADDR_W-1 -: 2];
  assign off     = addr[LUT_ADDR_W-3:0];
  assign idx_fwd = {1'b0, off};
  assign idx_rev = (LUT_ADDR_W-1)'(QTR) - idx_fwd;  // Reaches QTR at off 0.
  assign c_fwd   = cos_rom[idx_fwd];
  assign c_rev   = cos_rom[idx_rev];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Quadrant folding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (quad)
      2'd0: begin cos_v = c_fwd;  sin_v = c_rev;  end
      2'd1: begin cos_v = -c_rev; sin_v = c_fwd;  end
      2'd2: begin cos_v = -c_fwd; sin_v = -c_rev; end
      default: begin cos_v = c_rev; sin_v = -c_fwd; end
    endcase
  end

  logic    out_valid;
  logic    out_last;
  sample_t out_i;
  sample_t out_q;
  osc_t    out_cos;
  osc_t    out_sin;
  logic    take;

  assign take       = !out_valid || o_out.ready;
  assign i_in.ready = take;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= i_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take && i_in.valid) begin
      out_last <= i_in.last;
      out_i    <= i_in.i;
      out_q    <= i_in.q;
      out_cos  <= cos_v;
      out_sin  <= sin_v;
    end
  end

  assign o_out.valid = out_valid;
  assign o_out.last  = out_last;
  assign o_out.i     = out_i;
  assign o_out.q     = out_q;
  assign o_out.ph    = {out_cos, out_sin};  // Cosine in the upper half.

  a_hold: assert property (@(posedge clk) disable iff (i_rst)
    (o_out.valid && !o_out.ready) |=>
      (o_out.valid && $stable(o_out.last) && $stable(o_out.i) &&
       $stable(o_out.q) && $stable(o_out.ph)));

endmodule

// ==== complex_mixer.sv ====
`timescale 1ns/1ps

module complex_mixer import tag_rx_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  iq_stream_if.sink   i_in,
  iq_stream_if.source o_out
);

  typedef logic signed [SAMPLE_W+OSC_W-1:0] prod_t;
  typedef logic signed [SAMPLE_W+OSC_W:0]   sum_t;

  localparam sum_t ROUND = sum_t'(1) <<< (OSC_W - 2);  // Half of 2**(OSC_W-1).

  osc_t c_in;
  osc_t s_in;

  assign c_in = osc_t'(i_in.ph[2*OSC_W-1:OSC_W]);
  assign s_in = osc_t'(i_in.ph[OSC_W-1:0]);

  logic  a_valid;
  logic  a_last;
  prod_t p_ic;
  prod_t p_qs;
  prod_t p_is;
  prod_t p_qc;

  logic b_valid;
  logic b_last;
  mix_t mix_i;
  mix_t mix_q;

  logic a_take;
  logic b_take;
  sum_t sum_i;
  sum_t sum_q;

  assign b_take     = !b_valid || o_out.ready;
  assign a_take     = !a_valid || b_take;
  assign i_in.ready = a_take;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Products
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (i_rst) begin
      a_valid <= 1'b0;
    end else if (a_take) begin
      a_valid <= i_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (a_take && i_in.valid) begin
      a_last <= i_in.last;
      p_ic   <= prod_t'(i_in.i) * prod_t'(c_in);
      p_qs   <= prod_t'(i_in.q) * prod_t'(s_in);
      p_is   <= prod_t'(i_in.i) * prod_t'(s_in);
      p_qc   <= prod_t'(i_in.q) * prod_t'(c_in);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sums, rounded half up
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sum_i = sum_t'(p_ic) - sum_t'(p_qs) + ROUND;
  assign sum_q = sum_t'(p_is) + sum_t'(p_qc) + ROUND;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      b_valid <= 1'b0;
    end else if (b_take) begin
      b_valid <= a_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (b_take && a_valid) begin
      b_last <= a_last;
      mix_i  <= mix_t'(sum_i >>> (OSC_W - 1));  // The sum stays below 2**31, so the quotient fits.
      mix_q  <= mix_t'(sum_q >>> (OSC_W - 1));
    end
  end

  assign o_out.valid = b_valid;
  assign o_out.last  = b_last;
  assign o_out.i     = mix_i;
  assign o_out.q     = mix_q;
  assign o_out.ph    = '0;  // The mix link has no side field.

endmodule

// ==== gain_round_clip.sv ====
`timescale 1ns/1ps

module gain_round_clip import tag_rx_pkg::*; #(
  parameter gain_t GAIN = 18'd16384
) (
  input  logic      clk,
  input  logic      i_rst,
  iq_stream_if.sink i_in,
  output logic      o_valid,
  output logic      o_last,
  output sample_t   o_i,
  output sample_t   o_q,
  input  logic      i_ready
);

  typedef logic signed [MIX_W+GAIN_W:0] gprod_t;

  localparam logic signed [GAIN_W:0] GAIN_S = {1'b0, GAIN};  // Gain is never negative.
  localparam gprod_t HALF    = gprod_t'(1) <<< (GAIN_FRAC - 1);
  localparam gprod_t SAT_MAX = gprod_t'(2 ** (SAMPLE_W - 1) - 1);
  localparam gprod_t SAT_MIN = -gprod_t'(2 ** (SAMPLE_W - 1));

  logic   a_valid;
  logic   a_last;
  gprod_t g_i;
  gprod_t g_q;

  logic    b_valid;
  logic    b_last;
  sample_t b_i;
  sample_t b_q;

  logic   a_take;
  logic   b_take;
  gprod_t r_i;
  gprod_t r_q;

  assign b_take     = !b_valid || i_ready;
  assign a_take     = !a_valid || b_take;
  assign i_in.ready = a_take;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      a_valid <= 1'b0;
    end else if (a_take) begin
      a_valid <= i_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (a_take && i_in.valid) begin
      a_last <= i_in.last;
      g_i    <= gprod_t'(i_in.i) * gprod_t'(GAIN_S);
      g_q    <= gprod_t'(i_in.q) * gprod_t'(GAIN_S);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round half up, then clip to the sample range.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign r_i = (g_i + HALF) >>> GAIN_FRAC;
  assign r_q = (g_q + HALF) >>> GAIN_FRAC;

  function automatic sample_t clip(input gprod_t v);
    if (v > SAT_MAX) begin
      return sample_t'(SAT_MAX);
    end else if (v < SAT_MIN) begin
      return sample_t'(SAT_MIN);
    end
    return sample_t'(v);
  endfunction

  always_ff @(posedge clk) begin
    if (i_rst) begin
      b_valid <= 1'b0;
    end else if (b_take) begin
      b_valid <= a_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (b_take && a_valid) begin
      b_last <= a_last;
      b_i    <= clip(r_i);
      b_q    <= clip(r_q);
    end
  end

  assign o_valid = b_valid;
  assign o_last  = b_last;
  assign o_i     = b_i;
  assign o_q     = b_q;

  a_out_hold: assert property (@(posedge clk) disable iff (i_rst)
    (o_valid && !i_ready) |=>
      (o_valid && $stable(o_last) && $stable(o_i) && $stable(o_q)));

endmodule

// ==== tag_rx.sv ====
`timescale 1ns/1ps

module tag_rx import tag_rx_pkg::*; #(
  parameter phase_t      NSIG         = 24'd40960,
  parameter logic [15:0] NSYMB        = 16'd512,
  parameter phase_t      DPH_INC      = 24'hffc000,  // -16384
  parameter phase_t      START_PH_INC = 24'hfff000,  // -4096
  parameter phase_t      START_PH     = 24'h000000,
  parameter phase_t      NPH_SHIFT    = 24'h000000,
  parameter int          SYNC_BITS    = 4,
  parameter gain_t       GAIN         = 18'd16384
) (
  input  logic        clk,
  input  logic        i_rst,

  input  logic        i_in_valid,
  input  logic        i_in_last,
  input  sample_t     i_in_i,
  input  sample_t     i_in_q,
  output logic        o_in_ready,

  output logic        o_out_valid,
  output logic        o_out_last,
  output sample_t     o_out_i,
  output sample_t     o_out_q,
  input  logic        i_out_ready,

  output logic        o_sync_ready,

  output phase_t      o_phase,
  output phase_t      o_sample_n,
  output logic [15:0] o_symbol_n
);

  iq_stream_if #(.iq_t(sample_t), .ph_t(phase_t))              phase_s ();
  iq_stream_if #(.iq_t(sample_t), .ph_t(logic [2*OSC_W-1:0])) osc_s ();
  iq_stream_if #(.iq_t(mix_t),    .ph_t(logic))                mix_s ();

  chirp_phase_gen #(
    .NSIG         (NSIG),
    .NSYMB        (NSYMB),
    .DPH_INC      (DPH_INC),
    .START_PH_INC (START_PH_INC),
    .START_PH     (START_PH),
    .NPH_SHIFT    (NPH_SHIFT),
    .SYNC_BITS    (SYNC_BITS)
  ) u_phase (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_valid      (i_in_valid),
    .i_last       (i_in_last),
    .i_i          (i_in_i),
    .i_q          (i_in_q),
    .o_ready      (o_in_ready),
    .o_out        (phase_s),
    .o_sync_ready (o_sync_ready),
    .o_phase      (o_phase),
    .o_sample_n   (o_sample_n),
    .o_symbol_n   (o_symbol_n)
  );

  sincos_lut u_lut (
    .clk   (clk),
    .i_rst (i_rst),
    .i_in  (phase_s),
    .o_out (osc_s)
  );

  complex_mixer u_mix (
    .clk   (clk),
    .i_rst (i_rst),
    .i_in  (osc_s),
    .o_out (mix_s)
  );

  gain_round_clip #(
    .GAIN (GAIN)
  ) u_gain (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_in    (mix_s),
    .o_valid (o_out_valid),
    .o_last  (o_out_last),
    .o_i     (o_out_i),
    .o_q     (o_out_q),
    .i_ready (i_out_ready)
  );

endmodule

// ==== tb_tag_rx.sv ====
`timescale 1ns/1ps

module tb_tag_rx import tag_rx_pkg::*; ();

  localparam phase_t      NSIG         = 24'd8;
  localparam logic [15:0] NSYMB        = 16'd4;
  localparam phase_t      DPH_INC      = 24'h008000;
  localparam phase_t      START_PH_INC = 24'h010000;
  localparam phase_t      START_PH     = 24'h000000;
  localparam phase_t      NPH_SHIFT    = 24'h040000;
  localparam int          SYNC_BITS    = 2;
  localparam longint      GAIN_VAL     = 64'sd20480;  // 1.25 in Q14.
  localparam int          FRAME_LEN    = 32;
  localparam int          TMO          = 200;
  localparam real         PI           = 3.14159265358979;

  logic        clk = 1'b0;
  logic        i_rst;
  logic        i_in_valid;
  logic        i_in_last;
  sample_t     i_in_i;
  sample_t     i_in_q;
  logic        o_in_ready;
  logic        o_out_valid;
  logic        o_out_last;
  sample_t     o_out_i;
  sample_t     o_out_q;
  logic        i_out_ready;
  logic        o_sync_ready;
  phase_t      o_phase;
  phase_t      o_sample_n;
  logic [15:0] o_symbol_n;

  tag_rx #(
    .NSIG         (NSIG),
    .NSYMB        (NSYMB),
    .DPH_INC      (DPH_INC),
    .START_PH_INC (START_PH_INC),
    .START_PH     (START_PH),
    .NPH_SHIFT    (NPH_SHIFT),
    .SYNC_BITS    (SYNC_BITS),
    .GAIN         (gain_t'(GAIN_VAL))
  ) uut (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_in_valid   (i_in_valid),
    .i_in_last    (i_in_last),
    .i_in_i       (i_in_i),
    .i_in_q       (i_in_q),
    .o_in_ready   (o_in_ready),
    .o_out_valid  (o_out_valid),
    .o_out_last   (o_out_last),
    .o_out_i      (o_out_i),
    .o_out_q      (o_out_q),
    .i_out_ready  (i_out_ready),
    .o_sync_ready (o_sync_ready),
    .o_phase      (o_phase),
    .o_sample_n   (o_sample_n),
    .o_symbol_n   (o_symbol_n)
  );

  always #50 clk = ~clk;

  int          errors = 0;
  int          checks = 0;
  string       cur_test = "init";
  logic [31:0] rng = 32'ha5ea;
  logic        rand_ready = 1'b0;
  logic        lat_check = 1'b0;
  longint      cyc = 0;
  sample_t     last_i;
  sample_t     last_q;

  // Reference model state of the chirp counters.
  logic [SYNC_BITS-1:0] m_frame;
  phase_t               m_phase;
  phase_t               m_start;
  phase_t               m_inc;
  phase_t               m_sn;
  logic [15:0]          m_sym;

  longint exp_i[$];
  longint exp_q[$];
  logic   exp_last[$];
  longint in_cyc[$];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic void reset_model();
    m_frame = '1;
    m_phase = START_PH;
    m_start = START_PH;
    m_inc   = START_PH_INC;
    m_sn    = NSIG;
    m_sym   = NSYMB;
  endfunction

  function automatic void step_model();
    if (m_sn == NSIG && m_sym == NSYMB) begin
      m_sn    = phase_t'(1);
      m_sym   = 16'd1;
      m_phase = START_PH;
      m_inc   = START_PH_INC;
      m_start = START_PH - NPH_SHIFT;
      m_frame = m_frame + 1'b1;
    end else if (m_sn == NSIG) begin
      m_sn    = phase_t'(1);
      m_sym   = m_sym + 16'd1;
      m_phase = m_start;  // Uses the start phase before it moves on.
      m_inc   = m_inc + DPH_INC;
      m_start = m_start - NPH_SHIFT;
    end else begin
      m_phase = m_phase + m_inc;
      m_sn    = m_sn + phase_t'(1);
    end
  endfunction

  function automatic longint round_real(input real x);
    if (x >= 0.0)
      return longint'($rtoi(x + 0.5));
    return -longint'($rtoi(0.5 - x));
  endfunction

  function automatic longint saturate(input longint v);
    if (v > 64'sd32767)
      return 64'sd32767;
    if (v < -64'sd32768)
      return -64'sd32768;
    return v;
  endfunction

  function automatic void expect_out(input longint si, input longint sq, input phase_t ph,
                                     output longint oi, output longint oq);
    real    ang;
    longint c;
    longint s;
    longint mi;
    longint mq;
    ang = 2.0 * PI * real'(ph[PHASE_W-1 -: LUT_ADDR_W]) / 1024.0;
    c   = round_real(32767.0 * $cos(ang));
    s   = round_real(32767.0 * $sin(ang));
    mi  = (si * c - sq * s + 64'sd16384) >>> 15;
    mq  = (si * s + sq * c + 64'sd16384) >>> 15;
    oi  = saturate((mi * GAIN_VAL + 64'sd8192) >>> 14);
    oq  = saturate((mq * GAIN_VAL + 64'sd8192) >>> 14);
  endfunction

  task automatic compare_val(input string what, input longint expv, input longint act,
                             input longint tol);
    checks++;
    assert (act - expv <= tol && expv - act <= tol) else begin
      $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, expv, act);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin : scoreboard
    longint ei;
    longint eq;
    longint lat;
    if (i_rst) begin
      reset_model();
      exp_i.delete();
      exp_q.delete();
      exp_last.delete();
      in_cyc.delete();
    end else begin
      if (o_out_valid && i_out_ready) begin
        assert (exp_i.size() != 0) else begin
          $display("%s: an output sample appeared with none expected", cur_test);
          errors++;
        end
        if (exp_i.size() != 0) begin
          compare_val("out i", exp_i.pop_front(), longint'(o_out_i), 2);
          compare_val("out q", exp_q.pop_front(), longint'(o_out_q), 2);
          compare_val("out last", longint'(exp_last.pop_front()), longint'(o_out_last), 0);
          lat = cyc - in_cyc.pop_front();
          if (lat_check)
            compare_val("latency", 6, lat, 0);
        end
        last_i = o_out_i;
        last_q = o_out_q;
      end
      if (i_in_valid && o_in_ready) begin  // Sample takes the phase held before this edge.
        expect_out(longint'(i_in_i), longint'(i_in_q), m_phase, ei, eq);
        exp_i.push_back(ei);
        exp_q.push_back(eq);
        exp_last.push_back(i_in_last);
        in_cyc.push_back(cyc);
        step_model();
      end
    end
    cyc++;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_edge();
    logic [31:0] r;
    @(posedge clk);
    if (rand_ready) begin
      r = next_rand();
      i_out_ready <= (r[1:0] != 2'b00);  // Ready about three cycles in four.
    end
  endtask

  task automatic apply_reset();
    i_rst <= 1'b1;
    repeat (5) next_edge();
    i_rst <= 1'b0;
  endtask

  task automatic push_sample(input sample_t si, input sample_t sq, input logic last);
    int n;
    n = 0;
    i_in_valid <= 1'b1;
    i_in_i     <= si;
    i_in_q     <= sq;
    i_in_last  <= last;
    next_edge();
    while (!o_in_ready && n < TMO) begin
      next_edge();
      n++;
    end
    assert (n < TMO) else begin
      $display("%s: timed out waiting for the input to be accepted", cur_test);
      errors++;
    end
    i_in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (exp_i.size() != 0 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    assert (n < TMO) else begin
      $display("%s: timed out waiting for the pipeline to drain", cur_test);
      errors++;
    end
    next_edge();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_after_reset();
    cur_test = "reset";
    apply_reset();
    next_edge();
    @(negedge clk);
    compare_val("o_out_valid", 0, longint'(o_out_valid), 0);
    compare_val("o_sync_ready", 1, longint'(o_sync_ready), 0);
    compare_val("o_in_ready", 1, longint'(o_in_ready), 0);
    next_edge();
  endtask

  task automatic follow_phase_rule();
    logic [31:0] r;
    cur_test = "phase";
    apply_reset();
    for (int k = 0; k < 3 * FRAME_LEN + 1; k++) begin  // One extra sample wraps the frame count.
      r = next_rand();
      push_sample(sample_t'(r[15:0]), sample_t'(r[31:16]), 1'b0);
      @(negedge clk);
      compare_val("o_phase", longint'(m_phase), longint'(o_phase), 0);
      compare_val("o_sample_n", longint'(m_sn), longint'(o_sample_n), 0);
      compare_val("o_symbol_n", longint'(m_sym), longint'(o_symbol_n), 0);
      compare_val("o_sync_ready", longint'(&m_frame), longint'(o_sync_ready), 0);
      next_edge();
    end
    wait_drain();
  endtask

  task automatic stream_latency();
    logic [31:0] r;
    cur_test = "stream";
    i_out_ready <= 1'b1;
    lat_check = 1'b1;
    for (int k = 0; k < 24; k++) begin
      r = next_rand();
      push_sample(sample_t'(r[15:0]), sample_t'(r[31:16]), k == 23);
    end
    wait_drain();
    lat_check = 1'b0;
  endtask

  task automatic zero_and_full_scale();
    cur_test = "edges";
    apply_reset();
    push_sample(sample_t'(32767), sample_t'(0), 1'b0);  // First sample after reset sits at phase 0.
    wait_drain();
    @(negedge clk);
    compare_val("full scale i", 32767, longint'(last_i), 0);
    compare_val("full scale q", 0, longint'(last_q), 0);
    next_edge();
    push_sample(sample_t'(0), sample_t'(0), 1'b1);
    wait_drain();
    @(negedge clk);
    compare_val("zero i", 0, longint'(last_i), 0);
    compare_val("zero q", 0, longint'(last_q), 0);
    next_edge();
  endtask

  task automatic random_flow();
    logic [31:0] r;
    cur_test = "random";
    rand_ready = 1'b1;
    for (int k = 0; k < 80; k++) begin
      r = next_rand();
      push_sample(sample_t'(r[15:0]), sample_t'(r[31:16]), r[7]);
      r = next_rand();
      repeat (int'(r[1:0])) next_edge();
    end
    rand_ready = 1'b0;
    i_out_ready <= 1'b1;
    wait_drain();
  endtask

  task automatic fill_and_hold();
    logic [31:0] r;
    int          accepted;
    int          low_cnt;
    int          n;
    logic        held_last;
    sample_t     held_i;
    sample_t     held_q;
    cur_test = "fill";
    accepted = 0;
    low_cnt  = 0;
    n        = 0;
    r = next_rand();
    i_out_ready <= 1'b0;
    i_in_valid  <= 1'b1;
    i_in_i      <= sample_t'(r[15:0]);
    i_in_q      <= sample_t'(r[31:16]);
    i_in_last   <= r[3];
    while (low_cnt < 3 && n < TMO) begin
      next_edge();
      n++;
      if (o_in_ready) begin
        accepted++;
        r = next_rand();
        i_in_i    <= sample_t'(r[15:0]);
        i_in_q    <= sample_t'(r[31:16]);
        i_in_last <= r[3];
      end else begin
        low_cnt++;
      end
    end
    i_in_valid <= 1'b0;
    compare_val("samples in flight", 6, longint'(accepted), 0);
    @(negedge clk);
    compare_val("o_in_ready when full", 0, longint'(o_in_ready), 0);
    held_last = o_out_last;
    held_i    = o_out_i;
    held_q    = o_out_q;
    repeat (4) begin
      @(negedge clk);
      compare_val("held valid", 1, longint'(o_out_valid), 0);
      compare_val("held last", longint'(held_last), longint'(o_out_last), 0);
      compare_val("held i", longint'(held_i), longint'(o_out_i), 0);
      compare_val("held q", longint'(held_q), longint'(o_out_q), 0);
    end
    next_edge();
    i_out_ready <= 1'b1;
    wait_drain();
  endtask

  initial begin
    i_rst       = 1'b1;
    i_in_valid  = 1'b0;
    i_in_last   = 1'b0;
    i_in_i      = '0;
    i_in_q      = '0;
    i_out_ready = 1'b1;
    @(posedge clk);
    check_after_reset();
    follow_phase_rule();
    stream_latency();
    zero_and_full_scale();
    random_flow();
    fill_and_hold();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
tag_rx_pkg.sv
iq_stream_if.sv
chirp_phase_gen.sv
sincos_lut.sv
complex_mixer.sv
gain_round_clip.sv
tag_rx.sv
tb_tag_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tag_rx testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_tag_rx -f src.f

./obj_dir/Vtb_tag_rx | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
